// ==== burst_fsm.sv ====
//------------------------------------------------------------
// Burst state machine with status and consumption reporting.
// Strobes are one cycle wide, their payloads hold until the
// next strobe. Enable low parks the FSM in the purge state.
//------------------------------------------------------------
`timescale 1ns/100ps

module burst_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    input  logic                        error_policy_next,
    input  logic                        now,
    input  logic                        late,
    input  tx_ctrl_pkg::fifo_beat_t      head_beat,
    input  logic                        head_valid,
    input  logic                        stream_ready,
    input  logic                        bad_seq,
    input  logic                        seq_plus_one,
    input  tx_ctrl_pkg::seq_num_t        expected_seq,
    output tx_ctrl_pkg::ctrl_state_e     state,
    output logic                        status_strobe,
    output tx_ctrl_pkg::status_payload_t status_payload,
    output logic                        consume_strobe,
    output tx_ctrl_pkg::seq_num_t        consumed_seq
);

    tx_ctrl_pkg::seq_num_t head_seq;

    assign head_seq = head_beat.seq_num;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= tx_ctrl_pkg::idle;
            status_strobe  <= 1'b0;
            status_payload <= '0;
            consume_strobe <= 1'b0;
            consumed_seq   <= '0;
        end else if (!enable) begin
            // Discard everything while disabled
            state          <= tx_ctrl_pkg::error;
            status_strobe  <= 1'b0;
            status_payload <= '0;
            consume_strobe <= 1'b0;
            consumed_seq   <= '0;
        end else begin
            status_strobe  <= 1'b0;
            consume_strobe <= 1'b0;
            case (state)
                //--------------------------------------------------------
                // There is no start marker; the first valid entry
                // opens the burst
                tx_ctrl_pkg::idle: begin
                    if (head_valid) begin
                        if (head_beat.async || now) begin
                            if (bad_seq) begin
                                state          <= tx_ctrl_pkg::error;
                                status_strobe  <= 1'b1;
                                status_payload <= tx_ctrl_pkg::make_status(
                                    tx_ctrl_pkg::seq_error_start, expected_seq, head_seq);
                            end else begin
                                state <= tx_ctrl_pkg::odd;
                            end
                        end else if (late) begin
                            // Sync burst whose start time has already passed
                            state          <= tx_ctrl_pkg::error;
                            status_strobe  <= 1'b1;
                            status_payload <= tx_ctrl_pkg::make_status(
                                tx_ctrl_pkg::late, '0, head_seq);
                        end
                    end
                end
                //--------------------------------------------------------
                // First sample of the head entry; all error checks live here
                tx_ctrl_pkg::odd: begin
                    if (stream_ready) begin
                        if (!head_valid) begin
                            state          <= tx_ctrl_pkg::error;
                            status_strobe  <= 1'b1;
                            status_payload <= tx_ctrl_pkg::make_status(
                                tx_ctrl_pkg::underflow, '0, head_seq);
                        end else if (seq_plus_one && error_policy_next) begin
                            // Probably one lost packet, so leave this one queued and
                            // restart on it from idle
                            state          <= tx_ctrl_pkg::idle;
                            status_strobe  <= 1'b1;
                            status_payload <= tx_ctrl_pkg::make_status(
                                tx_ctrl_pkg::seq_error_mid, expected_seq, head_seq);
                        end else if (bad_seq) begin
                            state          <= tx_ctrl_pkg::error;
                            status_strobe  <= 1'b1;
                            status_payload <= tx_ctrl_pkg::make_status(
                                tx_ctrl_pkg::seq_error_mid, expected_seq, head_seq);
                        end else if (head_beat.eop && head_beat.eob && head_beat.odd) begin
                            state          <= tx_ctrl_pkg::idle;
                            status_strobe  <= 1'b1;
                            status_payload <= tx_ctrl_pkg::make_status(
                                tx_ctrl_pkg::eob_ack, '0, head_seq);
                            consume_strobe <= 1'b1;
                            consumed_seq   <= head_seq;
                        end else if (head_beat.eop && head_beat.odd) begin
                            // Odd-length packet ends, next entry starts on its first sample
                            consume_strobe <= 1'b1;
                            consumed_seq   <= head_seq;
                        end else begin
                            state <= tx_ctrl_pkg::even;
                        end
                    end
                end
                //--------------------------------------------------------
                // Second sample; the entry pops on the way out
                tx_ctrl_pkg::even: begin
                    if (stream_ready) begin
                        if (head_beat.eop && head_beat.eob) begin
                            state          <= tx_ctrl_pkg::idle;
                            status_strobe  <= 1'b1;
                            status_payload <= tx_ctrl_pkg::make_status(
                                tx_ctrl_pkg::eob_ack, '0, head_seq);
                            consume_strobe <= 1'b1;
                            consumed_seq   <= head_seq;
                        end else begin
                            state <= tx_ctrl_pkg::odd;
                            if (head_beat.eop) begin
                                consume_strobe <= 1'b1;
                                consumed_seq   <= head_seq;
                            end
                        end
                    end
                end
                //--------------------------------------------------------
                // Purge one entry per cycle up to the boundary the
                // policy asks for
                tx_ctrl_pkg::error: begin
                    if (head_valid && head_beat.eop) begin
                        consume_strobe <= 1'b1;
                        consumed_seq   <= head_seq;
                        if (head_beat.eob || error_policy_next) begin
                            state <= tx_ctrl_pkg::idle;
                        end
                    end
                end
                default: begin
                    state <= tx_ctrl_pkg::idle;
                end
            endcase
        end
    end

endmodule

// ==== compile.f ====
tx_ctrl_pkg.sv
seq_tracker.sv
burst_fsm.sv
sample_router.sv
tx_sample_ctrl.sv
tx_sample_ctrl_chk.sv
tb_tx_sample_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_tx_sample_ctrl \
    -f compile.f \
    -o tb_sim || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/tb_sim)"
echo "$sim_out"

echo "$sim_out" | grep -q "TEST PASSED" && exit 0 || exit 1

// ==== sample_router.sv ====
//------------------------------------------------------------
// Zero-latency sample routing and FIFO pop control.
// Data and run are only live in cycles with stream_ready high;
// otherwise zeros go downstream.
//------------------------------------------------------------
`timescale 1ns/100ps

module sample_router (
    input  logic                    clk,
    input  logic                    rst,
    input  tx_ctrl_pkg::ctrl_state_e state,
    input  tx_ctrl_pkg::fifo_beat_t  head_beat,
    input  logic                    head_valid,
    input  logic                    bad_seq,
    input  logic                    stream_ready,
    output logic                    head_ready,
    output logic                    run,
    output logic                    stream_valid,
    output tx_ctrl_pkg::iq_sample_t  stream_data
);

    logic send_first;
    logic send_second;

    // A first sample is withheld when it is missing or out of sequence
    assign send_first  = stream_ready && state == tx_ctrl_pkg::odd && head_valid && !bad_seq;
    assign send_second = stream_ready && state == tx_ctrl_pkg::even;

    always_comb begin
        stream_data = '0;
        if (send_first) begin
            stream_data.i = head_beat.samples.i0;
            stream_data.q = head_beat.samples.q0;
        end else if (send_second) begin
            stream_data.i = head_beat.samples.i1;
            stream_data.q = head_beat.samples.q1;
        end
    end

    assign run = send_first || send_second;

    // Purge every cycle in error, otherwise pop after the last sample of the entry
    assign head_ready = (state == tx_ctrl_pkg::error) ||
                        (state == tx_ctrl_pkg::even && stream_ready) ||
                        (state == tx_ctrl_pkg::odd && stream_ready &&
                         head_beat.odd && head_beat.eop);

    // The stream always carries a word once out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_valid <= 1'b0;
        end else begin
            stream_valid <= 1'b1;
        end
    end

endmodule

// ==== seq_tracker.sv ====
//------------------------------------------------------------
// Expected sequence number tracking, modulo 256.
// Restarts from zero at every burst boundary.
//------------------------------------------------------------
`timescale 1ns/100ps

module seq_tracker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,
    input  logic                    error_policy_next,
    input  tx_ctrl_pkg::ctrl_state_e state,
    input  tx_ctrl_pkg::fifo_beat_t  head_beat,
    input  logic                    head_valid,
    input  logic                    head_ready,
    input  logic                    stream_ready,
    output tx_ctrl_pkg::seq_num_t    expected_seq,
    output logic                    bad_seq,
    output logic                    seq_plus_one
);

    tx_ctrl_pkg::seq_num_t next_seq;
    logic                  pop;
    logic                  clr_seq;
    logic                  inc_seq;

    assign next_seq = expected_seq + 1'b1;
    assign pop      = head_valid && head_ready;

    // A finished burst, a burst-policy purge or a disabled purge all
    // restart the count
    assign clr_seq = (pop && head_beat.eop && head_beat.eob) ||
                     (state == tx_ctrl_pkg::error && !error_policy_next) ||
                     (state == tx_ctrl_pkg::error && !enable);

    // A lost packet mid-burst bumps the count so that the next packet
    // lines up again
    assign inc_seq = (pop && head_beat.eop) ||
                     (state == tx_ctrl_pkg::odd && stream_ready && head_valid &&
                      seq_plus_one);

    always_ff @(posedge clk) begin
        if (rst) begin
            expected_seq <= '0;
        end else if (clr_seq) begin
            expected_seq <= '0;
        end else if (inc_seq) begin
            // Wraps at 256 by design
            expected_seq <= next_seq;
        end
    end

    assign bad_seq      = head_beat.seq_num != expected_seq;
    assign seq_plus_one = head_beat.seq_num == next_seq;

endmodule

// ==== tb_tx_sample_ctrl.sv ====
//------------------------------------------------------------
// Directed testbench for the transmit sample controller.
// A queue models the FIFO; inputs change on the falling edge,
// outputs are logged on the rising edge. Seed 65.
//------------------------------------------------------------
`timescale 1ns/100ps

module tb_tx_sample_ctrl;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         enable;
    logic                         error_policy_next;
    tx_ctrl_pkg::fifo_beat_t      head_beat;
    logic                         head_valid;
    logic                         head_ready;
    logic                         now;
    logic                         late;
    logic                         status_strobe;
    tx_ctrl_pkg::status_payload_t status_payload;
    logic                         consume_strobe;
    tx_ctrl_pkg::seq_num_t        consumed_seq;
    logic                         run;
    logic                         stream_valid;
    tx_ctrl_pkg::iq_sample_t      stream_data;
    logic                         stream_ready;

    tx_ctrl_pkg::fifo_beat_t      fifo[$];
    tx_ctrl_pkg::iq_sample_t      out_q[$];
    tx_ctrl_pkg::iq_sample_t      exp_q[$];
    tx_ctrl_pkg::status_payload_t stat_q[$];
    tx_ctrl_pkg::seq_num_t        cons_q[$];
    logic                         run_hist[$];
    int                           hr_low;
    int                           nz_cnt;
    int                           errors = 0;
    int                           checks = 0;
    int                           tests = 0;
    logic                         aborted = 1'b0;
    logic                         ready_gaps = 1'b0;

    always #2 clk = ~clk;

    tx_sample_ctrl i_dut (.*);

    //------------------------------------------------------------
    // Pops the FIFO and logs the outputs using the values before the edge
    always @(posedge clk) begin
        if (!rst) begin
            if (head_valid && head_ready && fifo.size() > 0) void'(fifo.pop_front());
            if (run) out_q.push_back(stream_data);
            if (status_strobe) stat_q.push_back(status_payload);
            if (consume_strobe) cons_q.push_back(consumed_seq);
            run_hist.push_back(run);
            if (!head_ready) hr_low++;
            if (stream_data != '0) nz_cnt++;
        end
    end

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
        end
    endtask

    // Advances one cycle and drives the new FIFO head and stream_ready on the falling edge
    task automatic step();
        @(negedge clk);
        head_valid = fifo.size() > 0;
        head_beat  = (fifo.size() > 0) ? fifo[0] : '0;
        stream_ready = ready_gaps ? (($urandom % 4) != 0) : 1'b1;
    endtask

    // Pushes one entry and records the samples that it should send
    task automatic push_beat(input int seq, input logic async, input logic eop,
                             input logic eob, input logic odd, input logic expect_out);
        tx_ctrl_pkg::fifo_beat_t b;
        tx_ctrl_pkg::iq_sample_t s;
        b.samples.i0 = 16'($urandom);
        b.samples.q0 = 16'($urandom);
        b.samples.i1 = 16'($urandom);
        b.samples.q1 = 16'($urandom);
        b.seq_num    = 8'(seq);
        b.async      = async;
        b.eop        = eop;
        b.eob        = eob;
        b.odd        = odd;
        fifo.push_back(b);
        if (expect_out) begin
            s.i = b.samples.i0;
            s.q = b.samples.q0;
            exp_q.push_back(s);
            if (!odd) begin
                s.i = b.samples.i1;
                s.q = b.samples.q1;
                exp_q.push_back(s);
            end
        end
    endtask

    task automatic clear_logs();
        out_q.delete();
        exp_q.delete();
        stat_q.delete();
        cons_q.delete();
        run_hist.delete();
        hr_low = 0;
        nz_cnt = 0;
    endtask

    // Waits for n status strobes when which is 0, for n consume strobes when
    // which is 1 and for an empty FIFO otherwise
    task automatic wait_count(input int which, input int n, input string what);
        int cnt;
        int done;
        cnt = 0;
        done = 0;
        while (!aborted && done == 0) begin
            case (which)
                0: done = (stat_q.size() >= n) ? 1 : 0;
                1: done = (cons_q.size() >= n) ? 1 : 0;
                default: done = (fifo.size() == 0) ? 1 : 0;
            endcase
            if (done == 0) begin
                step();
                cnt++;
                if (cnt > 300) begin
                    $display("Timeout while waiting for %s", what);
                    errors++;
                    aborted = 1'b1;
                end
            end
        end
    endtask

    task automatic compare_samples(input string name);
        check_eq(64'(out_q.size()), 64'(exp_q.size()), {name, ": sample count"});
        foreach (exp_q[k]) begin
            if (k < out_q.size()) check_eq(64'(out_q[k]), 64'(exp_q[k]), {name, ": sample"});
        end
    endtask

    task automatic expect_status(input int idx, input tx_ctrl_pkg::status_code_e code,
                                 input int exp_seq, input int seq, input string name);
        if (idx >= stat_q.size()) begin
            errors++;
            $display("Missing status strobe %0d in %s", idx, name);
        end else begin
            check_eq(64'(stat_q[idx].code), 64'(code), {name, ": status code"});
            check_eq(64'(stat_q[idx].zero), 64'd0, {name, ": status zero field"});
            check_eq(64'(stat_q[idx].expected), 64'(exp_seq), {name, ": status expected"});
            check_eq(64'(stat_q[idx].seq), 64'(seq), {name, ": status seq"});
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("%-22s finished, %0d errors so far", name, errors);
        repeat (3) step();
    endtask

    //------------------------------------------------------------
    task automatic async_even_burst();
        clear_logs();
        ready_gaps = 1'b1;
        push_beat(0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        push_beat(0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        push_beat(1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        push_beat(1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1);
        wait_count(0, 1, "eob_ack of the async burst");
        ready_gaps = 1'b0;
        step();
        compare_samples("async burst");
        check_eq(64'(cons_q.size()), 64'd2, "async burst: consume count");
        if (cons_q.size() == 2) begin
            check_eq(64'(cons_q[0]), 64'd0, "async burst: first consumed seq");
            check_eq(64'(cons_q[1]), 64'd1, "async burst: second consumed seq");
        end
        expect_status(0, tx_ctrl_pkg::eob_ack, 0, 1, "async burst");
        finish_test("async even burst");
    endtask

    task automatic odd_length_packet();
        int ones;
        int first;
        int last;
        clear_logs();
        push_beat(0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
        push_beat(1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        push_beat(1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1);
        wait_count(0, 1, "eob_ack after the odd packet");
        step();
        compare_samples("odd packet");
        ones = 0;
        first = -1;
        last = -1;
        foreach (run_hist[k]) begin
            if (run_hist[k]) begin
                ones++;
                if (first < 0) first = k;
                last = k;
            end
        end
        // Contiguous run means no zero word between the two packets
        check_eq(64'(last - first + 1), 64'(ones), "odd packet: gap in run");
        expect_status(0, tx_ctrl_pkg::eob_ack, 0, 1, "odd packet");
        finish_test("odd-length packet");
    endtask

    task automatic underflow_purge();
        int sent;
        clear_logs();
        push_beat(0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        wait_count(0, 1, "underflow status");
        sent = out_q.size();
        compare_samples("underflow");
        expect_status(0, tx_ctrl_pkg::underflow, 0, 0, "underflow");
        repeat (4) step();
        // Late entries of the broken packet are thrown away
        push_beat(0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        push_beat(0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        wait_count(1, 1, "purge consume strobe");
        step();
        check_eq(64'(out_q.size()), 64'(sent), "underflow: samples sent during purge");
        check_eq(64'(cons_q.size()), 64'd1, "underflow: consume count");
        if (cons_q.size() > 0) check_eq(64'(cons_q[0]), 64'd0, "underflow: consumed seq");
        finish_test("underflow");
    endtask

    task automatic start_seq_error();
        clear_logs();
        push_beat(3, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        wait_count(1, 1, "purge after start sequence error");
        step();
        expect_status(0, tx_ctrl_pkg::seq_error_start, 0, 3, "seq error start");
        check_eq(64'(out_q.size()), 64'd0, "seq error start: samples sent");
        if (cons_q.size() > 0) check_eq(64'(cons_q[0]), 64'd3, "seq error start: consumed seq");
        finish_test("seq error at start");
    endtask

    task automatic sync_start_and_late();
        clear_logs();
        late = 1'b1;
        push_beat(0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        wait_count(1, 1, "purge of the late burst");
        late = 1'b0;
        expect_status(0, tx_ctrl_pkg::late, 0, 0, "late");
        push_beat(0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        repeat (12) step();
        check_eq(64'(out_q.size()), 64'd0, "sync: samples before now");
        now = 1'b1;
        wait_count(0, 2, "eob_ack of the timed burst");
        now = 1'b0;
        step();
        compare_samples("sync");
        expect_status(1, tx_ctrl_pkg::eob_ack, 0, 0, "sync");
        finish_test("sync start and late");
    endtask

    task automatic disabled_discard();
        enable = 1'b0;
        push_beat(0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        push_beat(0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        push_beat(1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        repeat (2) step();
        clear_logs();
        wait_count(2, 0, "FIFO drain while disabled");
        repeat (3) step();
        check_eq(64'(hr_low), 64'd0, "disable: cycles with head_ready low");
        check_eq(64'(nz_cnt), 64'd0, "disable: nonzero stream words");
        check_eq(64'(out_q.size()), 64'd0, "disable: samples with run high");
        check_eq(64'(stat_q.size()), 64'd0, "disable: status strobes");
        finish_test("disable");
    endtask

    initial begin
        rst = 1'b1;
        enable = 1'b1;
        error_policy_next = 1'b1;
        now = 1'b0;
        late = 1'b0;
        head_valid = 1'b0;
        head_beat = '0;
        stream_ready = 1'b0;
        void'($urandom(65));
        repeat (4) @(negedge clk);
        // Registered outputs come out of reset low
        check_eq(64'(stream_valid), 64'd0, "stream_valid in reset");
        check_eq(64'(status_strobe), 64'd0, "status_strobe in reset");
        check_eq(64'(consume_strobe), 64'd0, "consume_strobe in reset");
        check_eq(64'(status_payload), 64'd0, "status_payload in reset");
        check_eq(64'(consumed_seq), 64'd0, "consumed_seq in reset");
        rst = 1'b0;
        step();
        check_eq(64'(stream_valid), 64'd1, "stream_valid after reset");
        if (!aborted) async_even_burst();
        if (!aborted) odd_length_packet();
        if (!aborted) underflow_purge();
        if (!aborted) start_seq_error();
        if (!aborted) sync_start_and_late();
        if (!aborted) disabled_discard();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tx_ctrl_pkg.sv ====
//------------------------------------------------------------
// Shared types for the transmit sample controller.
// Sequence numbers are modulo 256. Each FIFO entry carries two
// complex samples, and only the first is valid when odd is set.
//------------------------------------------------------------
package tx_ctrl_pkg;

    // Widths of the sequence number, one IQ component and status
    localparam int seq_w    = 8;
    localparam int iq_w     = 16;
    localparam int status_w = 64;

    typedef logic [seq_w-1:0] seq_num_t;

    // One stream word, I in the upper half
    typedef struct packed {
        logic [iq_w-1:0] i;
        logic [iq_w-1:0] q;
    } iq_sample_t;

    typedef struct packed {
        logic [iq_w-1:0] i0;
        logic [iq_w-1:0] q0;
        logic [iq_w-1:0] i1;
        logic [iq_w-1:0] q1;
    } sample_pair_t;

    // One FIFO entry, 76 bits
    typedef struct packed {
        sample_pair_t samples;
        seq_num_t     seq_num;
        logic         async;
        logic         eop;
        logic         eob;
        logic         odd;
    } fifo_beat_t;

    // Idle waits for a burst start, odd and even hand out the two
    // samples of the head entry, error purges the FIFO
    typedef enum logic [1:0] {
        idle,
        odd,
        even,
        error
    } ctrl_state_e;

    typedef enum logic [31:0] {
        eob_ack         = 32'd1,
        underflow       = 32'd2,
        seq_error_start = 32'd3,
        seq_error_mid   = 32'd4,
        late            = 32'd5
    } status_code_e;

    typedef struct packed {
        status_code_e code;
        logic [15:0]  zero;
        seq_num_t     expected;
        seq_num_t     seq;
    } status_payload_t;

    // Builds a status word; expected is only meaningful for sequence errors
    function automatic status_payload_t make_status(status_code_e code, seq_num_t expected,
                                                    seq_num_t seq);
        status_payload_t p;
        p.code     = code;
        p.zero     = '0;
        p.expected = expected;
        p.seq      = seq;
        return p;
    endfunction

endpackage

// ==== tx_sample_ctrl.sv ====
//------------------------------------------------------------
// Transmit sample controller between a two-sample FIFO and a
// sample datapath. One sample leaves per stream_ready cycle.
// head_ready depends combinationally on stream_ready.
//------------------------------------------------------------
`timescale 1ns/100ps

module tx_sample_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    input  logic                        error_policy_next,
    input  tx_ctrl_pkg::fifo_beat_t      head_beat,
    input  logic                        head_valid,
    output logic                        head_ready,
    input  logic                        now,
    input  logic                        late,
    output logic                        status_strobe,
    output tx_ctrl_pkg::status_payload_t status_payload,
    output logic                        consume_strobe,
    output tx_ctrl_pkg::seq_num_t        consumed_seq,
    output logic                        run,
    output logic                        stream_valid,
    output tx_ctrl_pkg::iq_sample_t      stream_data,
    input  logic                        stream_ready
);

    tx_ctrl_pkg::ctrl_state_e state;
    tx_ctrl_pkg::seq_num_t    expected_seq;
    logic                     bad_seq;
    logic                     seq_plus_one;

    //------------------------------------------------------------
    // Sequence tracking, burst control and routing all settle
    // within one cycle
    seq_tracker i_seq_tracker (
        .clk               (clk),
        .rst               (rst),
        .enable            (enable),
        .error_policy_next (error_policy_next),
        .state             (state),
        .head_beat         (head_beat),
        .head_valid        (head_valid),
        .head_ready        (head_ready),
        .stream_ready      (stream_ready),
        .expected_seq      (expected_seq),
        .bad_seq           (bad_seq),
        .seq_plus_one      (seq_plus_one)
    );

    burst_fsm i_burst_fsm (
        .clk               (clk),
        .rst               (rst),
        .enable            (enable),
        .error_policy_next (error_policy_next),
        .now               (now),
        .late              (late),
        .head_beat         (head_beat),
        .head_valid        (head_valid),
        .stream_ready      (stream_ready),
        .bad_seq           (bad_seq),
        .seq_plus_one      (seq_plus_one),
        .expected_seq      (expected_seq),
        .state             (state),
        .status_strobe     (status_strobe),
        .status_payload    (status_payload),
        .consume_strobe    (consume_strobe),
        .consumed_seq      (consumed_seq)
    );

    sample_router i_sample_router (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .head_beat    (head_beat),
        .head_valid   (head_valid),
        .bad_seq      (bad_seq),
        .stream_ready (stream_ready),
        .head_ready   (head_ready),
        .run          (run),
        .stream_valid (stream_valid),
        .stream_data  (stream_data)
    );

endmodule

// ==== tx_sample_ctrl_chk.sv ====
//------------------------------------------------------------
// Protocol checks for the transmit sample controller.
// Bound to every tx_sample_ctrl instance. All properties are
// sampled on the rising clock edge and are off during reset.
//------------------------------------------------------------
`timescale 1ns/100ps

module tx_sample_ctrl_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   status_strobe,
    input logic                   run,
    input logic                   stream_ready,
    input tx_ctrl_pkg::iq_sample_t stream_data
);

    // Status strobes are single-cycle pulses
    property p_status_single;
        @(posedge clk) disable iff (rst) status_strobe |=> !status_strobe;
    endproperty

    // A sample only counts as sent when the datapath takes it
    property p_run_needs_ready;
        @(posedge clk) disable iff (rst) run |-> stream_ready;
    endproperty

    // Idle cycles put zeros on the stream
    property p_zero_when_idle;
        @(posedge clk) disable iff (rst) !run |-> stream_data == '0;
    endproperty

    a_status_single: assert property (p_status_single)
        else $error("status_strobe high in two consecutive cycles");
    a_run_needs_ready: assert property (p_run_needs_ready)
        else $error("run high while stream_ready is low");
    a_zero_when_idle: assert property (p_zero_when_idle)
        else $error("stream_data not zero while run is low");

endmodule

bind tx_sample_ctrl tx_sample_ctrl_chk i_chk (
    .clk           (clk),
    .rst           (rst),
    .status_strobe (status_strobe),
    .run           (run),
    .stream_ready  (stream_ready),
    .stream_data   (stream_data)
);
